// ==== design/mini_rv_pkg.sv ====
`default_nettype none

package mini_rv_pkg;

	localparam int XLEN = 32;

	// ~~~~~~~~~~~~~~~~~~~~ Opcodes and ALU operations
	typedef enum logic [6:0] {
		opc_load   = 7'b0000011,
		opc_op_imm = 7'b0010011,
		opc_auipc  = 7'b0010111,
		opc_store  = 7'b0100011,
		opc_op     = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jalr   = 7'b1100111,
		opc_jal    = 7'b1101111,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b  // lui passes the U immediate
	} alu_op_e;

	// Branch conditions in funct3
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	// ~~~~~~~~~~~~~~~~~~~~ Instruction formats
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_word_u;

endpackage

`default_nettype wire

// ==== design/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if import mini_rv_pkg::*; ();

	opcode_e     opcode;
	logic [4:0]  rd;
	logic [2:0]  funct3;
	logic [31:0] imm;          // Sign-extended, already formatted
	alu_op_e     alu_op;
	logic        alu_use_imm;  // Operand b from imm
	logic        writes_rd;
	logic        is_ebreak;

	modport producer (
		output opcode, rd, funct3, imm, alu_op, alu_use_imm, writes_rd, is_ebreak
	);

	modport consumer (
		input opcode, rd, funct3, imm, alu_op, alu_use_imm, writes_rd, is_ebreak
	);

endinterface

`default_nettype wire

// ==== design/idu.sv ====
`timescale 1ns/1ns
`default_nettype none

module idu import mini_rv_pkg::*; (
	input  wire inst_word_u inst,
	output logic [4:0]      rs1_addr,
	output logic [4:0]      rs2_addr,
	decode_if.producer      dec
);

	opcode_e     opcode;
	logic [2:0]  funct3;
	logic        alt;       // funct7 bit 5 where it selects sub or sra
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	alu_op_e     alu_op;

	assign opcode   = inst.r_fmt.opcode;
	assign funct3   = inst.r_fmt.funct3;
	assign rs1_addr = inst.r_fmt.rs1;
	assign rs2_addr = inst.r_fmt.rs2;

	// ~~~~~~~~~~~~~~~~~~~~ Immediates
	assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
	assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
	assign imm_b = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
		inst.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
	assign imm_j = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
		inst.j_fmt.imm_10_1, 1'b0};

	always_comb begin
		case (opcode)
			opc_op_imm, opc_load, opc_jalr: dec.imm = imm_i;
			opc_store:                      dec.imm = imm_s;
			opc_branch:                     dec.imm = imm_b;
			opc_lui, opc_auipc:             dec.imm = imm_u;
			opc_jal:                        dec.imm = imm_j;
			default:                        dec.imm = '0;  // R-type and system
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~ ALU operation
	// For op_imm only the shift funct3 looks at funct7
	assign alt = inst.r_fmt.funct7[5] && (opcode == opc_op || funct3 == 3'b101);

	always_comb begin
		alu_op = alu_add;
		case (opcode)
			opc_op, opc_op_imm: begin
				case (funct3)
					3'b000:  alu_op = alt ? alu_sub : alu_add;
					3'b001:  alu_op = alu_sll;
					3'b010:  alu_op = alu_slt;
					3'b011:  alu_op = alu_sltu;
					3'b100:  alu_op = alu_xor;
					3'b101:  alu_op = alt ? alu_sra : alu_srl;
					3'b110:  alu_op = alu_or;
					default: alu_op = alu_and;
				endcase
			end
			opc_branch: alu_op = alu_sub;     // Zero test for beq and bne
			opc_lui:    alu_op = alu_pass_b;
			default:    alu_op = alu_add;     // auipc, jal, jalr targets
		endcase
	end

	assign dec.opcode      = opcode;
	assign dec.rd          = inst.r_fmt.rd;
	assign dec.funct3      = funct3;
	assign dec.alu_op      = alu_op;
	assign dec.alu_use_imm = opcode inside {opc_op_imm, opc_lui, opc_auipc, opc_jal, opc_jalr};
	assign dec.writes_rd   = opcode inside {opc_op, opc_op_imm, opc_lui, opc_auipc,
		opc_jal, opc_jalr};
	assign dec.is_ebreak   = (inst == EBREAK_WORD);

	// Shift immediates carry only the srli/srai funct7 codes
	always_comb begin
		if (!$isunknown(inst) && opcode == opc_op_imm && funct3[1:0] == 2'b01) begin
			assert (inst.r_fmt.funct7 == 7'b0000000 || inst.r_fmt.funct7 == 7'b0100000)
				else $error("idu: bad funct7 %b on shift immediate", inst.r_fmt.funct7);
		end
	end

endmodule

`default_nettype wire

// ==== design/gpr_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpr_file import mini_rv_pkg::*; #(
	parameter int GPR_COUNT = 32
) (
	input  wire              clk,
	input  wire              reset,
	input  wire  [4:0]       rs1_addr,
	input  wire  [4:0]       rs2_addr,
	output logic [XLEN-1:0]  rs1_data,
	output logic [XLEN-1:0]  rs2_data,
	input  wire              gpr_wen,
	input  wire  [4:0]       gpr_waddr,
	input  wire  [XLEN-1:0]  gpr_wdata
);

	localparam int AW = $clog2(GPR_COUNT);

	logic [XLEN-1:0] regs [GPR_COUNT];
	logic [AW-1:0]   rs1_idx;
	logic [AW-1:0]   rs2_idx;
	logic [AW-1:0]   wr_idx;

	// Upper address bits drop out for RV32E
	assign rs1_idx = rs1_addr[AW-1:0];
	assign rs2_idx = rs2_addr[AW-1:0];
	assign wr_idx  = gpr_waddr[AW-1:0];

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];  // x0 reads zero
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < GPR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (gpr_wen && wr_idx != '0) begin
			regs[wr_idx] <= gpr_wdata;
		end
	end

	// exu filters rd of zero before the strobe
	no_x0_write: assert property (@(posedge clk) disable iff (reset)
		gpr_wen |-> gpr_waddr != 5'd0);

endmodule

`default_nettype wire

// ==== design/exu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu import mini_rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
	input  wire                 clk,
	input  wire                 reset,
	decode_if.consumer          dec,
	input  wire  [XLEN-1:0]     rs1_data,
	input  wire  [XLEN-1:0]     rs2_data,
	output logic [31:0]         pc,
	output logic                gpr_wen,
	output logic [4:0]          gpr_waddr,
	output logic [XLEN-1:0]     gpr_wdata,
	output logic                trap
);

	logic [31:0] operand_a;
	logic [31:0] operand_b;
	logic [4:0]  shamt;
	logic [31:0] alu_result;
	logic [31:0] pc_plus4;
	logic        is_jump;
	logic        branch_taken;
	logic [31:0] next_pc;

	// ~~~~~~~~~~~~~~~~~~~~ ALU
	assign operand_a = (dec.opcode == opc_auipc || dec.opcode == opc_jal) ? pc : rs1_data;
	assign operand_b = dec.alu_use_imm ? dec.imm : rs2_data;
	assign shamt     = operand_b[4:0];

	always_comb begin
		case (dec.alu_op)
			alu_add:    alu_result = operand_a + operand_b;
			alu_sub:    alu_result = operand_a - operand_b;
			alu_sll:    alu_result = operand_a << shamt;
			alu_slt:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			alu_sltu:   alu_result = {31'b0, operand_a < operand_b};
			alu_xor:    alu_result = operand_a ^ operand_b;
			alu_srl:    alu_result = operand_a >> shamt;
			alu_sra:    alu_result = $unsigned($signed(operand_a) >>> shamt);
			alu_or:     alu_result = operand_a | operand_b;
			alu_and:    alu_result = operand_a & operand_b;
			alu_pass_b: alu_result = operand_b;
			default:    alu_result = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~ Branch and next pc
	always_comb begin
		case (dec.funct3)
			f3_beq:  branch_taken = (alu_result == '0);  // rs1 - rs2
			f3_bne:  branch_taken = (alu_result != '0);
			f3_blt:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
			f3_bge:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
			f3_bltu: branch_taken = rs1_data < rs2_data;
			f3_bgeu: branch_taken = rs1_data >= rs2_data;
			default: branch_taken = 1'b0;                // Reserved codes fall through
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign is_jump  = (dec.opcode == opc_jal || dec.opcode == opc_jalr);

	always_comb begin
		case (dec.opcode)
			opc_jal:    next_pc = alu_result;
			opc_jalr:   next_pc = {alu_result[31:1], 1'b0};
			opc_branch: next_pc = branch_taken ? pc + dec.imm : pc_plus4;
			default:    next_pc = pc_plus4;  // Also loads, stores, unknowns
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~ Write-back
	assign gpr_wen   = dec.writes_rd && dec.rd != 5'd0 && !trap && !reset;
	assign gpr_waddr = dec.rd;
	assign gpr_wdata = is_jump ? pc_plus4 : alu_result;  // Link address for jumps

	always_ff @(posedge clk) begin
		if (reset) begin
			pc   <= RESET_PC;
			trap <= 1'b0;
		end else if (!trap) begin
			trap <= dec.is_ebreak;
			if (!dec.is_ebreak) begin
				pc <= next_pc;  // Halts on the ebreak itself
			end
		end
	end

	pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/mini_rv_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mini_rv_top #(
	parameter logic [31:0] RESET_PC  = 32'h8000_0000,
	parameter int          GPR_COUNT = 32
) (
	input  wire        clk,
	input  wire        reset,
	input  wire [31:0] inst,
	output wire [31:0] pc,
	output wire        gpr_wen,
	output wire [4:0]  gpr_waddr,
	output wire [31:0] gpr_wdata,
	output wire        trap
);

	wire [4:0]  rs1_addr;
	wire [4:0]  rs2_addr;
	wire [31:0] rs1_data;
	wire [31:0] rs2_data;

	decode_if dec_if ();

	idu idu_i (
		.inst     (inst),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.dec      (dec_if.producer)
	);

	gpr_file #(.GPR_COUNT(GPR_COUNT)) gpr_file_i (
		.clk       (clk),
		.reset     (reset),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.gpr_wen   (gpr_wen),
		.gpr_waddr (gpr_waddr),
		.gpr_wdata (gpr_wdata)
	);

	exu #(.RESET_PC(RESET_PC)) exu_i (
		.clk       (clk),
		.reset     (reset),
		.dec       (dec_if.consumer),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.pc        (pc),
		.gpr_wen   (gpr_wen),
		.gpr_waddr (gpr_waddr),
		.gpr_wdata (gpr_wdata),
		.trap      (trap)
	);

endmodule

`default_nettype wire

// ==== verification/mini_rv_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mini_rv_tb import mini_rv_pkg::*; ();

	localparam logic [31:0] RESET_PC   = 32'h8000_0000;
	localparam int          RAND_COUNT = 20;
	localparam int          HALT_STEPS = 3;

	logic        clk;
	logic        reset;
	logic [31:0] inst;
	wire  [31:0] pc;
	wire         gpr_wen;
	wire  [4:0]  gpr_waddr;
	wire  [31:0] gpr_wdata;
	wire         trap;

	inst_word_u  prog_inst[$];   // Program table, indexed by (pc - RESET_PC) / 4
	logic        prog_wen[$];
	logic [4:0]  prog_waddr[$];
	logic [31:0] prog_wdata[$];
	int          prog_step[$];   // Next pc in words from the row's own pc
	logic [31:0] shadow [32];
	int          errors = 0;
	int          tests = 0;
	int          failed_tests = 0;
	int          cycle_count = 0;
	int          cycle_limit = 1000;

	mini_rv_top #(.RESET_PC(RESET_PC), .GPR_COUNT(32)) mini_rv_top_i (
		.clk       (clk),
		.reset     (reset),
		.inst      (inst),
		.pc        (pc),
		.gpr_wen   (gpr_wen),
		.gpr_waddr (gpr_waddr),
		.gpr_wdata (gpr_wdata),
		.trap      (trap)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ Instruction assembly
	function automatic inst_word_u r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		inst_word_u w;
		w.r_fmt = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opc_op};
		return w;
	endfunction

	function automatic inst_word_u i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, opcode_e op);
		inst_word_u w;
		w.i_fmt = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
		return w;
	endfunction

	function automatic inst_word_u s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		inst_word_u w;
		w.s_fmt = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3, imm_4_0: imm[4:0],
			opcode: opc_store};
		return w;
	endfunction

	function automatic inst_word_u b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		inst_word_u w;
		w.b_fmt = '{imm_12: off[12], imm_10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
			imm_4_1: off[4:1], imm_11: off[11], opcode: opc_branch};
		return w;
	endfunction

	function automatic inst_word_u u_type(logic [19:0] imm, logic [4:0] rd, opcode_e op);
		inst_word_u w;
		w.u_fmt = '{imm_31_12: imm, rd: rd, opcode: op};
		return w;
	endfunction

	function automatic inst_word_u j_type(logic [20:0] off, logic [4:0] rd);
		inst_word_u w;
		w.j_fmt = '{imm_20: off[20], imm_10_1: off[10:1], imm_11: off[11],
			imm_19_12: off[19:12], rd: rd, opcode: opc_jal};
		return w;
	endfunction

	function automatic logic [31:0] row_pc();
		return RESET_PC + 32'(4 * prog_inst.size());
	endfunction

	task automatic add_row(inst_word_u w, logic wen, logic [4:0] waddr, logic [31:0] wdata,
			int step);
		prog_inst.push_back(w);
		prog_wen.push_back(wen);
		prog_waddr.push_back(waddr);
		prog_wdata.push_back(wdata);
		prog_step.push_back(step);
	endtask

	// Lands in the shadow of a taken branch or jump, so its write flags a wrong pc
	task automatic skip_row();
		add_row(i_type(12'hfff, 5'd0, 3'b000, 5'd31, opc_op_imm), 1'b0, 5'd0, 32'h0, 1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~ Checks
	task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(string name, logic [4:0] got, logic [4:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s got x%0d expected x%0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// Entered 1 ns after a rising edge, leaves 1 ns after the next one
	task automatic run_step(inst_word_u w, logic exp_wen, logic [4:0] exp_waddr,
			logic [31:0] exp_wdata, logic [31:0] exp_pc, logic exp_trap);
		inst = w;
		#3;
		check_bit("gpr_wen", gpr_wen, exp_wen);
		if (exp_wen) begin
			check_reg("gpr_waddr", gpr_waddr, exp_waddr);
			check_word("gpr_wdata", gpr_wdata, exp_wdata);
		end
		@(posedge clk);
		#1;
		check_word("pc", pc, exp_pc);
		check_bit("trap", trap, exp_trap);
	endtask

	task automatic report_step(string label, int err_before);
		tests++;
		if (errors != err_before) begin
			failed_tests++;
			$display("%s: mismatch", label);
		end else begin
			$display("%s: ok", label);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~ Program table
	task automatic build_program();
		add_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_op_imm), 1'b1, 5'd1, 32'h0000_0005, 1);
		add_row(i_type(12'hffd, 5'd0, 3'b000, 5'd2, opc_op_imm), 1'b1, 5'd2, 32'hffff_fffd, 1);
		add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'h0000_0002, 1);
		add_row(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4), 1'b1, 5'd4, 32'hffff_fff8, 1);
		add_row(i_type(12'h0ff, 5'd1, 3'b100, 5'd5, opc_op_imm), 1'b1, 5'd5, 32'h0000_00fa, 1);
		add_row(i_type(12'h0f0, 5'd2, 3'b111, 5'd6, opc_op_imm), 1'b1, 5'd6, 32'h0000_00f0, 1);
		add_row(r_type(7'h00, 5'd6, 5'd1, 3'b110, 5'd7), 1'b1, 5'd7, 32'h0000_00f5, 1);
		add_row(r_type(7'h00, 5'd7, 5'd2, 3'b111, 5'd8), 1'b1, 5'd8, 32'h0000_00f5, 1);
		add_row(i_type(12'h004, 5'd1, 3'b001, 5'd9, opc_op_imm), 1'b1, 5'd9, 32'h0000_0050, 1);
		add_row(i_type(12'h01c, 5'd2, 3'b101, 5'd10, opc_op_imm), 1'b1, 5'd10, 32'h0000_000f, 1);
		add_row(i_type(12'h401, 5'd2, 3'b101, 5'd11, opc_op_imm), 1'b1, 5'd11, 32'hffff_fffe, 1);
		add_row(r_type(7'h20, 5'd1, 5'd4, 3'b101, 5'd12), 1'b1, 5'd12, 32'hffff_ffff, 1);
		add_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd13), 1'b1, 5'd13, 32'h0000_0001, 1);
		add_row(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd14), 1'b1, 5'd14, 32'h0000_0000, 1);
		add_row(i_type(12'hfff, 5'd1, 3'b011, 5'd15, opc_op_imm), 1'b1, 5'd15, 32'h0000_0001, 1);
		add_row(r_type(7'h00, 5'd1, 5'd4, 3'b101, 5'd16), 1'b1, 5'd16, 32'h07ff_ffff, 1);
		add_row(i_type(12'd7, 5'd1, 3'b000, 5'd0, opc_op_imm), 1'b0, 5'd0, 32'h0, 1);  // To x0
		add_row(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd17), 1'b1, 5'd17, 32'h0000_0005, 1);
		add_row(u_type(20'h12345, 5'd18, opc_lui), 1'b1, 5'd18, 32'h1234_5000, 1);
		add_row(u_type(20'h00001, 5'd19, opc_auipc), 1'b1, 5'd19, row_pc() + 32'h1000, 1);
		add_row(j_type(21'd8, 5'd20), 1'b1, 5'd20, row_pc() + 32'd4, 2);
		skip_row();
		// x20 + 13 is odd, bit 0 cleared lands two rows on
		add_row(i_type(12'd13, 5'd20, 3'b000, 5'd21, opc_jalr), 1'b1, 5'd21, row_pc() + 32'd4, 2);
		skip_row();
		// Branches on x1 = 5 and x2 = -3, taken ones hop over a skip row
		add_row(b_type(13'd8, 5'd1, 5'd1, f3_beq), 1'b0, 5'd0, 32'h0, 2);
		skip_row();
		add_row(b_type(13'd8, 5'd2, 5'd1, f3_beq), 1'b0, 5'd0, 32'h0, 1);
		add_row(b_type(13'd8, 5'd2, 5'd1, f3_bne), 1'b0, 5'd0, 32'h0, 2);
		skip_row();
		add_row(b_type(13'd8, 5'd1, 5'd1, f3_bne), 1'b0, 5'd0, 32'h0, 1);
		add_row(b_type(13'd8, 5'd1, 5'd2, f3_blt), 1'b0, 5'd0, 32'h0, 2);
		skip_row();
		add_row(b_type(13'd8, 5'd2, 5'd1, f3_blt), 1'b0, 5'd0, 32'h0, 1);
		add_row(b_type(13'd8, 5'd2, 5'd1, f3_bge), 1'b0, 5'd0, 32'h0, 2);
		skip_row();
		add_row(b_type(13'd8, 5'd1, 5'd2, f3_bge), 1'b0, 5'd0, 32'h0, 1);
		add_row(b_type(13'd8, 5'd2, 5'd1, f3_bltu), 1'b0, 5'd0, 32'h0, 2);
		skip_row();
		add_row(b_type(13'd8, 5'd1, 5'd2, f3_bltu), 1'b0, 5'd0, 32'h0, 1);
		add_row(b_type(13'd8, 5'd1, 5'd2, f3_bgeu), 1'b0, 5'd0, 32'h0, 2);
		skip_row();
		add_row(b_type(13'd8, 5'd2, 5'd1, f3_bgeu), 1'b0, 5'd0, 32'h0, 1);
		add_row(i_type(12'd0, 5'd1, 3'b010, 5'd24, opc_load), 1'b0, 5'd0, 32'h0, 1);
		add_row(s_type(12'd4, 5'd1, 5'd2, 3'b010), 1'b0, 5'd0, 32'h0, 1);
		add_row(32'h0000_0f0b, 1'b0, 5'd0, 32'h0, 1);  // custom-0 opcode
	endtask

	// ~~~~~~~~~~~~~~~~~~~~ Main sequence
	initial begin
		int          idx;
		int          err_before;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [11:0] imm;
		logic [31:0] sum;
		logic [31:0] end_pc;
		clk   = 1'b0;
		reset = 1'b1;
		inst  = i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_op_imm);  // Would write x1
		void'($urandom(32'hb827_6a73));
		for (int i = 0; i < 32; i++) begin
			shadow[i] = 32'h0;
		end
		build_program();
		cycle_limit = 2 * prog_inst.size() + RAND_COUNT + 20;
		end_pc = row_pc();

		repeat (4) @(posedge clk);
		#3;
		err_before = errors;
		check_bit("gpr_wen", gpr_wen, 1'b0);
		@(posedge clk);
		#1;
		reset = 1'b0;
		check_word("pc", pc, RESET_PC);
		check_bit("trap", trap, 1'b0);
		report_step("reset", err_before);

		while (pc != end_pc) begin
			idx = int'((pc - RESET_PC) >> 2);
			if (pc < RESET_PC || idx >= prog_inst.size()) begin
				$display("pc %h left the program table at t=%0t", pc, $time);
				errors++;
				break;
			end
			err_before = errors;
			run_step(prog_inst[idx], prog_wen[idx], prog_waddr[idx], prog_wdata[idx],
				RESET_PC + 32'(4 * (idx + prog_step[idx])), 1'b0);
			if (prog_wen[idx]) begin
				shadow[prog_waddr[idx]] = prog_wdata[idx];
			end
			report_step($sformatf("row %0d", idx), err_before);
		end

		for (int k = 0; k < RAND_COUNT; k++) begin
			rd  = 5'($urandom % 31) + 5'd1;  // Never x0
			rs1 = 5'($urandom);
			imm = 12'($urandom);
			sum = shadow[rs1] + {{20{imm[11]}}, imm};
			err_before = errors;
			run_step(i_type(imm, rs1, 3'b000, rd, opc_op_imm), 1'b1, rd, sum,
				end_pc + 32'(4 * (k + 1)), 1'b0);
			shadow[rd] = sum;
			report_step($sformatf("addi %0d x%0d = x%0d + %0d", k, rd, rs1,
				$signed(imm)), err_before);
		end

		// pc stays on the ebreak once trap is up
		end_pc = end_pc + 32'(4 * RAND_COUNT);
		err_before = errors;
		run_step(EBREAK_WORD, 1'b0, 5'd0, 32'h0, end_pc, 1'b1);
		report_step("ebreak", err_before);
		for (int k = 0; k < HALT_STEPS; k++) begin
			err_before = errors;
			run_step(i_type(12'd1, 5'd1, 3'b000, 5'd5, opc_op_imm), 1'b0, 5'd0, 32'h0,
				end_pc, 1'b1);
			report_step($sformatf("halted %0d", k), err_before);
		end

		$display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mini_rv.f ====
design/mini_rv_pkg.sv
design/decode_if.sv
design/idu.sv
design/gpr_file.sv
design/exu.sv
design/mini_rv_top.sv
verification/mini_rv_tb.sv

// ==== Makefile ====
# Verilator build and run for the mini_rv core

SRCS := $(wildcard design/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vmini_rv_tb: mini_rv.f $(SRCS)
	verilator --binary --timing --assert --top-module mini_rv_tb \
		-f mini_rv.f -o Vmini_rv_tb

run: obj_dir/Vmini_rv_tb
	./obj_dir/Vmini_rv_tb | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "Run failed"; exit 1; \
	fi
	@grep -q "Simulation PASSED" sim.log || { echo "Run ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log
